/* hw/procPkg.sv */
package procPkg;

   // Word, register and address width
   localparam int dataWidth = 16;

   // Eight general purpose registers
   localparam int regAddrWidth = 3;

   // PC value loaded on reset unless the top level overrides it
   localparam logic [dataWidth-1:0] defaultResetPc = '0;

   // Opcode field, instruction bits 15..11
   typedef enum logic [4:0] {
      opHalt = 5'b00000,
      opNop  = 5'b00001,
      opJ    = 5'b00100,
      opAddi = 5'b01000,
      opBeqz = 5'b01100,
      opBnez = 5'b01101,
      opSt   = 5'b10000,
      opLd   = 5'b10001,
      opAdd  = 5'b11000,
      opSub  = 5'b11001,
      opAnd  = 5'b11010,
      opXor  = 5'b11011
   } opcodeT;

   // ALU function selected in decode
   typedef enum logic [1:0] {
      aluAdd = 2'b00,
      aluSub = 2'b01,
      aluAnd = 2'b10,
      aluXor = 2'b11
   } aluOpT;

   // Control transfer class, resolved in execute
   typedef enum logic [1:0] {
      brNone = 2'b00,
      brBeqz = 2'b01,
      brBnez = 2'b10,
      brJump = 2'b11
   } branchKindT;

endpackage

/* hw/pipeIfs.sv */
`timescale 1ns/1ps
`default_nettype none

// Decode/execute pipeline register
interface decodeExIf;
   import procPkg::*;

   logic valid;
   aluOpT aluOp;
   logic [dataWidth-1:0] rsData;
   logic [dataWidth-1:0] rtData;
   // Already sign-extended
   logic [dataWidth-1:0] imm;
   logic [dataWidth-1:0] pcNext;
   logic [regAddrWidth-1:0] rd;
   logic regWrite;
   logic useImm;
   logic memRead;
   logic memWrite;
   branchKindT branchKind;
   logic halt;

   modport src (output valid, aluOp, rsData, rtData, imm, pcNext, rd,
                regWrite, useImm, memRead, memWrite, branchKind, halt);
   modport dst (input valid, aluOp, rsData, rtData, imm, pcNext, rd,
                regWrite, useImm, memRead, memWrite, branchKind, halt);
   // Destination check for hazard detection
   modport watch (input valid, rd, regWrite);
endinterface

// Execute/memory pipeline register
interface exMemIf;
   import procPkg::*;

   logic valid;
   // ALU result, also the effective address of LD and ST
   logic [dataWidth-1:0] result;
   logic [dataWidth-1:0] storeData;
   logic [regAddrWidth-1:0] rd;
   logic regWrite;
   logic memRead;
   logic memWrite;
   logic halt;

   modport src (output valid, result, storeData, rd, regWrite, memRead, memWrite, halt);
   modport dst (input valid, result, storeData, rd, regWrite, memRead, memWrite, halt);
   modport watch (input valid, rd, regWrite);
endinterface

`default_nettype wire

/* hw/fetch.sv */
`timescale 1ns/1ps
`default_nettype none

module fetch #(
   parameter logic [procPkg::dataWidth-1:0] resetPc = procPkg::defaultResetPc
) (
   input  logic                          clk,
   input  logic                          reset,
   input  logic [procPkg::dataWidth-1:0] instr,
   input  logic                          stall,
   input  logic                          redirect,
   input  logic [procPkg::dataWidth-1:0] redirectTarget,
   input  logic                          halted,
   output logic [procPkg::dataWidth-1:0] instrAddr,
   output logic [procPkg::dataWidth-1:0] instrOut,
   output logic [procPkg::dataWidth-1:0] pcNextOut,
   output logic                          validOut
);
   import procPkg::*;

   logic [dataWidth-1:0] pc;
   logic [dataWidth-1:0] pcPlus2;

   // Byte addressed, one 16-bit instruction per step
   assign pcPlus2 = pc + dataWidth'(2);
   assign instrAddr = pc;

   // Redirect outranks a stall since the stalled instruction is younger
   always_ff @(posedge clk) begin
      if (reset) begin
         pc <= resetPc;
         validOut <= 1'b0;
      end else if (!halted) begin
         if (redirect) begin
            pc <= redirectTarget;
            validOut <= 1'b0;
         end else if (!stall) begin
            pc <= pcPlus2;
            validOut <= 1'b1;
         end
      end
   end

   // Fetch/decode payload
   always_ff @(posedge clk) begin
      if (!halted && !stall) begin
         instrOut <= instr;
         pcNextOut <= pcPlus2;
      end
   end

endmodule

`default_nettype wire

/* hw/decode.sv */
`timescale 1ns/1ps
`default_nettype none

module decode (
   input  logic                             clk,
   input  logic                             reset,
   input  logic [procPkg::dataWidth-1:0]    instrIn,
   input  logic [procPkg::dataWidth-1:0]    pcNextIn,
   input  logic                             validIn,
   input  logic                             redirect,
   input  logic                             wbWrite,
   input  logic [procPkg::regAddrWidth-1:0] wbRd,
   input  logic [procPkg::dataWidth-1:0]    wbData,
   decodeExIf.src                           dx,
   exMemIf.watch                            xm,
   output logic                             stall,
   output logic                             err
);
   import procPkg::*;

   logic [dataWidth-1:0] regFile [2**regAddrWidth];

   opcodeT opcode;
   logic [regAddrWidth-1:0] rsIdx;
   logic [regAddrWidth-1:0] rtIdx;
   logic [regAddrWidth-1:0] rdIdx;
   logic [dataWidth-1:0] rsData;
   logic [dataWidth-1:0] rtData;
   logic [dataWidth-1:0] immExt;
   aluOpT aluOp;
   branchKindT branchKind;
   logic legal;
   logic useRs;
   logic useRt;
   logic regWrite;
   logic useImm;
   logic memRead;
   logic memWrite;
   logic halt;
   logic rsHazard;
   logic rtHazard;
   logic live;
   logic issue;
   // Set once a HALT has passed into execute
   logic haltSeen;

   assign opcode = opcodeT'(instrIn[15:11]);
   assign rsIdx = instrIn[10:8];
   assign rtIdx = instrIn[7:5];

   always_comb begin
      legal = 1'b0;
      useRs = 1'b0;
      useRt = 1'b0;
      regWrite = 1'b0;
      useImm = 1'b0;
      memRead = 1'b0;
      memWrite = 1'b0;
      halt = 1'b0;
      aluOp = aluAdd;
      branchKind = brNone;
      rdIdx = instrIn[4:2];
      immExt = {{(dataWidth-5){instrIn[4]}}, instrIn[4:0]};
      case (opcode)
         opAdd, opSub, opAnd, opXor: begin
            legal = 1'b1;
            useRs = 1'b1;
            useRt = 1'b1;
            regWrite = 1'b1;
            case (opcode)
               opSub:   aluOp = aluSub;
               opAnd:   aluOp = aluAnd;
               opXor:   aluOp = aluXor;
               default: aluOp = aluAdd;
            endcase
         end
         opAddi, opLd: begin
            legal = 1'b1;
            useRs = 1'b1;
            useImm = 1'b1;
            regWrite = 1'b1;
            memRead = (opcode == opLd);
            rdIdx = rtIdx;
         end
         opSt: begin
            // Store source sits in the rt slot
            legal = 1'b1;
            useRs = 1'b1;
            useRt = 1'b1;
            useImm = 1'b1;
            memWrite = 1'b1;
         end
         opBeqz, opBnez: begin
            legal = 1'b1;
            useRs = 1'b1;
            branchKind = (opcode == opBeqz) ? brBeqz : brBnez;
            immExt = {{(dataWidth-8){instrIn[7]}}, instrIn[7:0]};
         end
         opJ: begin
            legal = 1'b1;
            branchKind = brJump;
            immExt = {{(dataWidth-11){instrIn[10]}}, instrIn[10:0]};
         end
         opHalt: begin
            legal = 1'b1;
            halt = 1'b1;
         end
         opNop: legal = 1'b1;
         default: legal = 1'b0;
      endcase
   end

   // Write before read covers the writeback stage
   assign rsData = (wbWrite && wbRd == rsIdx) ? wbData : regFile[rsIdx];
   assign rtData = (wbWrite && wbRd == rtIdx) ? wbData : regFile[rtIdx];

   always_ff @(posedge clk) begin
      if (wbWrite) begin
         regFile[wbRd] <= wbData;
      end
   end

   // Producers still in execute or memory
   assign rsHazard = useRs && ((dx.valid && dx.regWrite && dx.rd == rsIdx) ||
                               (xm.valid && xm.regWrite && xm.rd == rsIdx));
   assign rtHazard = useRt && ((dx.valid && dx.regWrite && dx.rd == rtIdx) ||
                               (xm.valid && xm.regWrite && xm.rd == rtIdx));

   assign live = validIn && !haltSeen;
   assign stall = live && (rsHazard || rtHazard);
   assign issue = live && !stall && !redirect;

   always_ff @(posedge clk) begin
      if (reset) begin
         dx.valid <= 1'b0;
         haltSeen <= 1'b0;
         err <= 1'b0;
      end else begin
         dx.valid <= issue;
         if (issue && halt) begin
            haltSeen <= 1'b1;
         end
         // Sticky, the instruction itself goes on as a NOP
         if (live && !redirect && !legal) begin
            err <= 1'b1;
         end
      end
   end

   always_ff @(posedge clk) begin
      dx.aluOp <= aluOp;
      dx.rsData <= rsData;
      dx.rtData <= rtData;
      dx.imm <= immExt;
      dx.pcNext <= pcNextIn;
      dx.rd <= rdIdx;
      dx.regWrite <= regWrite;
      dx.useImm <= useImm;
      dx.memRead <= memRead;
      dx.memWrite <= memWrite;
      dx.branchKind <= branchKind;
      dx.halt <= halt;
   end

endmodule

`default_nettype wire

/* hw/execute.sv */
`timescale 1ns/1ps
`default_nettype none

module execute (
   input  logic                          clk,
   input  logic                          reset,
   decodeExIf.dst                        dx,
   exMemIf.src                           xm,
   output logic                          redirect,
   output logic [procPkg::dataWidth-1:0] redirectTarget
);
   import procPkg::*;

   logic [dataWidth-1:0] opB;
   logic [dataWidth-1:0] aluResult;
   logic taken;

   // Immediate forms also compute LD/ST addresses through the adder
   assign opB = dx.useImm ? dx.imm : dx.rtData;

   always_comb begin
      case (dx.aluOp)
         aluSub:  aluResult = dx.rsData - opB;
         aluAnd:  aluResult = dx.rsData & opB;
         aluXor:  aluResult = dx.rsData ^ opB;
         default: aluResult = dx.rsData + opB;
      endcase
   end

   always_comb begin
      case (dx.branchKind)
         brBeqz:  taken = (dx.rsData == '0);
         brBnez:  taken = (dx.rsData != '0);
         brJump:  taken = 1'b1;
         default: taken = 1'b0;
      endcase
   end

   // Target is relative to the next sequential PC
   assign redirect = dx.valid && taken;
   assign redirectTarget = dx.pcNext + dx.imm;

   always_ff @(posedge clk) begin
      if (reset) begin
         xm.valid <= 1'b0;
      end else begin
         xm.valid <= dx.valid;
      end
   end

   always_ff @(posedge clk) begin
      xm.result <= aluResult;
      xm.storeData <= dx.rtData;
      xm.rd <= dx.rd;
      xm.regWrite <= dx.regWrite;
      xm.memRead <= dx.memRead;
      xm.memWrite <= dx.memWrite;
      xm.halt <= dx.halt;
   end

endmodule

`default_nettype wire

/* hw/memWb.sv */
`timescale 1ns/1ps
`default_nettype none

module memWb (
   input  logic                             clk,
   input  logic                             reset,
   input  logic [procPkg::dataWidth-1:0]    dataReadData,
   exMemIf.dst                              xm,
   output logic                             dataRead,
   output logic                             dataWrite,
   output logic [procPkg::dataWidth-1:0]    dataAddr,
   output logic [procPkg::dataWidth-1:0]    dataWriteData,
   output logic                             wbWrite,
   output logic [procPkg::regAddrWidth-1:0] wbRd,
   output logic [procPkg::dataWidth-1:0]    wbData,
   output logic                             halted
);
   logic wbValid;
   logic wbRegWrite;
   logic wbHalt;

   // Data memory answers in the same cycle
   assign dataRead = xm.valid && xm.memRead && !halted;
   assign dataWrite = xm.valid && xm.memWrite && !halted;
   assign dataAddr = xm.result;
   assign dataWriteData = xm.storeData;

   assign wbWrite = wbValid && wbRegWrite;

   always_ff @(posedge clk) begin
      if (reset) begin
         wbValid <= 1'b0;
         halted <= 1'b0;
      end else begin
         wbValid <= xm.valid && !halted;
         // Stays set until the next reset
         if (wbValid && wbHalt) begin
            halted <= 1'b1;
         end
      end
   end

   // Load data or ALU result into the writeback register
   always_ff @(posedge clk) begin
      wbRegWrite <= xm.regWrite;
      wbHalt <= xm.halt;
      wbRd <= xm.rd;
      wbData <= xm.memRead ? dataReadData : xm.result;
   end

endmodule

`default_nettype wire

/* hw/proc.sv */
`timescale 1ns/1ps
`default_nettype none

module proc #(
   parameter logic [procPkg::dataWidth-1:0] resetPc = procPkg::defaultResetPc
) (
   input  logic                          clk,
   input  logic                          reset,
   output logic [procPkg::dataWidth-1:0] instrAddr,
   input  logic [procPkg::dataWidth-1:0] instr,
   output logic                          dataRead,
   output logic                          dataWrite,
   output logic [procPkg::dataWidth-1:0] dataAddr,
   output logic [procPkg::dataWidth-1:0] dataWriteData,
   input  logic [procPkg::dataWidth-1:0] dataReadData,
   output logic                          halted,
   output logic                          err
);
   import procPkg::*;

   // Fetch/decode register
   logic [dataWidth-1:0] fdInstr;
   logic [dataWidth-1:0] fdPcNext;
   logic fdValid;

   logic stall;
   logic redirect;
   logic [dataWidth-1:0] redirectTarget;

   // Writeback into the register file
   logic wbWrite;
   logic [regAddrWidth-1:0] wbRd;
   logic [dataWidth-1:0] wbData;

   decodeExIf dxIf ();
   exMemIf xmIf ();

   fetch #(.resetPc(resetPc)) fetch0 (
      .clk            (clk),
      .reset          (reset),
      .instr          (instr),
      .stall          (stall),
      .redirect       (redirect),
      .redirectTarget (redirectTarget),
      .halted         (halted),
      .instrAddr      (instrAddr),
      .instrOut       (fdInstr),
      .pcNextOut      (fdPcNext),
      .validOut       (fdValid)
   );

   decode decode0 (
      .clk      (clk),
      .reset    (reset),
      .instrIn  (fdInstr),
      .pcNextIn (fdPcNext),
      .validIn  (fdValid),
      .redirect (redirect),
      .wbWrite  (wbWrite),
      .wbRd     (wbRd),
      .wbData   (wbData),
      .dx       (dxIf),
      .xm       (xmIf),
      .stall    (stall),
      .err      (err)
   );

   execute execute0 (
      .clk            (clk),
      .reset          (reset),
      .dx             (dxIf),
      .xm             (xmIf),
      .redirect       (redirect),
      .redirectTarget (redirectTarget)
   );

   memWb memWb0 (
      .clk           (clk),
      .reset         (reset),
      .dataReadData  (dataReadData),
      .xm            (xmIf),
      .dataRead      (dataRead),
      .dataWrite     (dataWrite),
      .dataAddr      (dataAddr),
      .dataWriteData (dataWriteData),
      .wbWrite       (wbWrite),
      .wbRd          (wbRd),
      .wbData        (wbData),
      .halted        (halted)
   );

endmodule

`default_nettype wire

/* sim/procTb.sv */
`timescale 1ns/1ps

module procTb;
   import procPkg::*;

   localparam logic [15:0] resetPc = 16'h0000;
   localparam int memWords = 256;

   logic clk;
   logic reset;
   logic [15:0] instrAddr;
   logic [15:0] instr;
   logic dataRead;
   logic dataWrite;
   logic [15:0] dataAddr;
   logic [15:0] dataWriteData;
   logic [15:0] dataReadData;
   logic halted;
   logic err;

   logic [15:0] instrMem [memWords];
   logic [15:0] dataMem [memWords];
   logic [15:0] prog [$];
   logic [15:0] logAddr [$];
   logic [15:0] logData [$];

   // Reference machine state
   bit [15:0] refRegs [8];
   bit [15:0] refMem [memWords];
   bit [15:0] expAddr [$];
   bit [15:0] expData [$];
   bit refErr;

   int cycles = 0;
   int totalLen = 0;
   logic [31:0] lcgState;

   proc #(.resetPc(resetPc)) dut0 (
      .clk           (clk),
      .reset         (reset),
      .instrAddr     (instrAddr),
      .instr         (instr),
      .dataRead      (dataRead),
      .dataWrite     (dataWrite),
      .dataAddr      (dataAddr),
      .dataWriteData (dataWriteData),
      .dataReadData  (dataReadData),
      .halted        (halted),
      .err           (err)
   );

   // Both memories answer in the same cycle and are word indexed
   assign instr = instrMem[instrAddr[8:1]];
   // Data memory answers only while dataRead is high
   assign dataReadData = dataRead ? dataMem[dataAddr[8:1]] : 16'h0000;

   initial begin
      clk = 1'b0;
      forever #4 clk = ~clk;
   end

   // Limit grows with every program loaded
   always @(posedge clk) begin
      cycles = cycles + 1;
      if (cycles > totalLen * 4 + 200) begin
         $display("*** FAILED ***");
         $fatal(1, "Timeout after %0d cycles, the processor never halted", cycles);
      end
   end

   // Store log taken mid-cycle while the data port is stable
   always @(negedge clk) begin
      if (!reset && dataWrite === 1'b1) begin
         logAddr.push_back(dataAddr);
         logData.push_back(dataWriteData);
         dataMem[dataAddr[8:1]] = dataWriteData;
      end
   end

   function automatic logic [15:0] regOp(logic [4:0] op, int rd, int rs, int rt);
      return {op, 3'(rs), 3'(rt), 3'(rd), 2'b00};
   endfunction

   // rd doubles as the store source for ST
   function automatic logic [15:0] immOp(logic [4:0] op, int rd, int rs, int imm);
      return {op, 3'(rs), 3'(rd), 5'(imm)};
   endfunction

   function automatic logic [15:0] branchOp(logic [4:0] op, int rs, int offset);
      return {op, 3'(rs), 8'(offset)};
   endfunction

   function automatic logic [15:0] jumpOp(int offset);
      return {opJ, 11'(offset)};
   endfunction

   function automatic logic [15:0] haltOp();
      return {opHalt, 11'd0};
   endfunction

   function automatic void emit(logic [15:0] word);
      prog.push_back(word);
   endfunction

   // XOR of a register with itself gives a known zero
   function automatic void clearRegs();
      for (int r = 0; r < 8; r++) begin
         emit(regOp(opXor, r, r, r));
      end
   endfunction

   function automatic logic [15:0] fillWord(int idx);
      logic [7:0] a;
      a = 8'(idx);
      return {a ^ 8'h5A, ~a};
   endfunction

   function automatic int nextRand(int range);
      lcgState = lcgState * 32'd1103515245 + 32'd12345;
      return int'(lcgState[30:16]) % range;
   endfunction

   // Instruction level model of the ISA that runs the loaded program to HALT
   function automatic void predict();
      logic [15:0] pc;
      logic [15:0] w;
      logic [15:0] pcNext;
      logic [15:0] ea;
      int steps;
      bit done;
      pc = resetPc;
      steps = 0;
      done = 1'b0;
      refErr = 1'b0;
      expAddr.delete();
      expData.delete();
      while (!done && steps < 2000) begin
         w = instrMem[pc[8:1]];
         pcNext = pc + 16'd2;
         ea = refRegs[w[10:8]] + {{11{w[4]}}, w[4:0]};
         pc = pcNext;
         steps++;
         case (w[15:11])
            opAdd:  refRegs[w[4:2]] = refRegs[w[10:8]] + refRegs[w[7:5]];
            opSub:  refRegs[w[4:2]] = refRegs[w[10:8]] - refRegs[w[7:5]];
            opAnd:  refRegs[w[4:2]] = refRegs[w[10:8]] & refRegs[w[7:5]];
            opXor:  refRegs[w[4:2]] = refRegs[w[10:8]] ^ refRegs[w[7:5]];
            opAddi: refRegs[w[7:5]] = ea;
            opLd:   refRegs[w[7:5]] = refMem[ea[8:1]];
            opSt: begin
               refMem[ea[8:1]] = refRegs[w[7:5]];
               expAddr.push_back(ea);
               expData.push_back(refRegs[w[7:5]]);
            end
            opBeqz: begin
               if (refRegs[w[10:8]] == 16'd0) begin
                  pc = pcNext + {{8{w[7]}}, w[7:0]};
               end
            end
            opBnez: begin
               if (refRegs[w[10:8]] != 16'd0) begin
                  pc = pcNext + {{8{w[7]}}, w[7:0]};
               end
            end
            opJ:    pc = pcNext + {{5{w[10]}}, w[10:0]};
            opHalt: done = 1'b1;
            opNop:  ;
            default: refErr = 1'b1;
         endcase
      end
   endfunction

   task automatic checkThat(input bit ok, input string msg);
      assert (ok) else begin
         $display("CHECK FAILED at %0d ns: %s", $time, msg);
         $display("*** FAILED ***");
         $fatal(1, "Stopping at the first error");
      end
   endtask

   // Unused words decode as HALT with the address in the spare bits
   task automatic fillMemories();
      for (int i = 0; i < memWords; i++) begin
         instrMem[i] = {opHalt, 11'(i)};
         dataMem[i] = fillWord(i);
         refMem[i] = fillWord(i);
      end
   endtask

   task automatic applyReset();
      @(posedge clk);
      #1 reset = 1'b1;
      repeat (2) @(posedge clk);
      #1 reset = 1'b0;
      checkThat(instrAddr === resetPc, "instrAddr is not resetPc after reset");
      checkThat(halted === 1'b0 && err === 1'b0, "halted or err high after reset");
      checkThat(dataWrite === 1'b0 && dataRead === 1'b0, "data port active after reset");
   endtask

   task automatic runProgram(input string name);
      fillMemories();
      foreach (prog[i]) begin
         instrMem[i] = prog[i];
      end
      totalLen += prog.size();
      predict();
      logAddr.delete();
      logData.delete();
      applyReset();
      do begin
         @(posedge clk);
         #1;
      end while (halted !== 1'b1);
      checkThat(err === refErr, $sformatf("%s: err is %b", name, err));
      checkThat(logAddr.size() == expAddr.size(),
                $sformatf("%s: %0d stores, expected %0d", name, logAddr.size(), expAddr.size()));
      foreach (expAddr[i]) begin
         checkThat(logAddr[i] === expAddr[i] && logData[i] === expData[i],
                   $sformatf("%s: store %0d wrote %h to %h, expected %h to %h", name, i,
                             logData[i], logAddr[i], expData[i], expAddr[i]));
      end
   endtask

   task automatic exerciseAlu();
      prog.delete();
      clearRegs();
      emit(immOp(opAddi, 1, 0, 5));
      emit(immOp(opAddi, 2, 0, -3));
      emit(immOp(opAddi, 7, 0, 14));
      emit(regOp(opAdd, 3, 1, 2));
      emit(regOp(opSub, 4, 1, 2));
      emit(regOp(opAnd, 5, 1, 2));
      emit(regOp(opXor, 6, 1, 2));
      emit(immOp(opSt, 3, 7, 0));
      emit(immOp(opSt, 4, 7, 2));
      emit(immOp(opSt, 5, 7, 4));
      emit(immOp(opSt, 6, 7, 6));
      emit(immOp(opAddi, 1, 1, -8));
      emit(immOp(opSt, 1, 7, 8));
      emit(immOp(opSt, 2, 7, 10));
      emit(haltOp());
      runProgram("alu");
   endtask

   task automatic loadUseHazards();
      prog.delete();
      clearRegs();
      emit(immOp(opAddi, 2, 0, 12));
      emit(immOp(opAddi, 1, 0, 9));
      emit(immOp(opSt, 1, 2, 0));
      emit(immOp(opLd, 3, 2, 0));
      emit(immOp(opAddi, 4, 3, 7));
      emit(immOp(opSt, 4, 2, 2));
      // This word is never stored and comes from the fill pattern
      emit(immOp(opLd, 5, 2, 6));
      emit(regOp(opXor, 6, 5, 3));
      emit(regOp(opAdd, 6, 6, 4));
      emit(immOp(opSt, 6, 2, 4));
      emit(haltOp());
      runProgram("load-use");
   endtask

   // Shadow stores of taken transfers write FFFF from r7
   task automatic controlFlow();
      prog.delete();
      clearRegs();
      emit(immOp(opAddi, 1, 0, 1));
      emit(immOp(opAddi, 7, 0, -1));
      emit(immOp(opAddi, 6, 0, 14));
      emit(branchOp(opBeqz, 0, 4));
      emit(immOp(opSt, 7, 6, 0));
      emit(immOp(opSt, 7, 6, 2));
      emit(immOp(opSt, 1, 6, 4));
      emit(branchOp(opBeqz, 1, 4));
      emit(immOp(opSt, 1, 6, 6));
      emit(immOp(opSt, 0, 6, 8));
      emit(branchOp(opBnez, 1, 4));
      emit(immOp(opSt, 7, 6, 0));
      emit(immOp(opSt, 7, 6, 2));
      emit(branchOp(opBnez, 0, 4));
      emit(immOp(opSt, 1, 6, 10));
      emit(immOp(opSt, 1, 6, 12));
      emit(jumpOp(4));
      emit(immOp(opSt, 7, 6, 0));
      emit(immOp(opSt, 7, 6, 2));
      // Countdown loop closed by a backward BNEZ
      emit(immOp(opAddi, 3, 0, 3));
      emit(immOp(opAddi, 3, 3, -1));
      emit(immOp(opSt, 3, 6, 14));
      emit(branchOp(opBnez, 3, -6));
      emit(haltOp());
      runProgram("branch");
   endtask

   task automatic haltFreeze();
      logic [15:0] held;
      int count;
      prog.delete();
      clearRegs();
      emit(immOp(opAddi, 1, 0, 6));
      emit(immOp(opSt, 1, 1, 0));
      emit(haltOp());
      emit(immOp(opSt, 1, 1, 2));
      runProgram("halt");
      held = instrAddr;
      count = logData.size();
      repeat (20) begin
         @(posedge clk);
         #1;
         checkThat(halted === 1'b1, "halted dropped before reset");
         checkThat(instrAddr === held, "instrAddr moved after halt");
         checkThat(dataWrite === 1'b0 && dataRead === 1'b0, "data port active after halt");
      end
      checkThat(logData.size() == count, "store logged after halt");
   endtask

   task automatic illegalOpcode();
      prog.delete();
      clearRegs();
      emit(immOp(opAddi, 6, 0, 8));
      emit(immOp(opAddi, 1, 0, 3));
      emit(immOp(opSt, 1, 6, 0));
      // Opcode 11111 is unassigned
      emit(16'hF8E5);
      emit(immOp(opAddi, 2, 1, 4));
      emit(immOp(opSt, 2, 6, 2));
      emit(haltOp());
      runProgram("illegal");
      repeat (5) @(posedge clk);
      #1;
      checkThat(err === 1'b1, "err did not stay high");
   endtask

   task automatic randomArithmetic();
      int kind;
      int rd;
      int rs;
      int rt;
      prog.delete();
      clearRegs();
      // Store base r7 = 30 is left out of the random destinations
      emit(immOp(opAddi, 7, 0, 15));
      emit(immOp(opAddi, 7, 7, 15));
      for (int i = 0; i < 30; i++) begin
         kind = nextRand(3);
         rd = 1 + nextRand(6);
         rs = nextRand(7);
         rt = nextRand(7);
         case (kind)
            0: emit(immOp(opAddi, rd, rs, nextRand(32)));
            1: emit(regOp(opAdd, rd, rs, rt));
            default: emit(regOp(opXor, rd, rs, rt));
         endcase
         emit(immOp(opSt, rd, 7, 2 * nextRand(8)));
      end
      emit(haltOp());
      runProgram("random");
   endtask

   initial begin
      reset = 1'b1;
      lcgState = 32'd49219;
      fillMemories();
      exerciseAlu();
      loadUseHazards();
      controlFlow();
      haltFreeze();
      illegalOpcode();
      randomArithmetic();
      $display("*** PASSED ***");
      $finish;
   end

endmodule

/* flist.f */
hw/procPkg.sv
hw/pipeIfs.sv
hw/fetch.sv
hw/decode.sv
hw/execute.sv
hw/memWb.sv
hw/proc.sv
sim/procTb.sv

/* run.sh */
#!/bin/sh
# Compile the processor and its testbench with Verilator, then run it
set -e
cd "$(dirname "$0")"
verilator --binary --timescale 1ns/1ps -Wno-fatal --top-module procTb -f flist.f -o procTbSim
./obj_dir/procTbSim
